// File: common/rf_pkg.sv
`default_nettype none

package rf_pkg;

  // architectural data word for registers, the pc and CSR values.
  typedef logic [31:0] xlen_t;

  // RV32E has sixteen general registers.
  typedef logic [3:0] reg_idx_t;

  typedef logic [11:0] csr_addr_t;

  // machine CSR addresses.
  localparam csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_MVENDORID = 12'hF11;
  localparam csr_addr_t CSR_MARCHID   = 12'hF12;

  // read-only ID values.
  localparam xlen_t MVENDORID_VALUE = 32'h7973_7978;
  localparam xlen_t MARCHID_VALUE   = 32'h017D_C685;

  // mstatus with MPP set to machine mode for reset and ecall.
  localparam xlen_t MSTATUS_RESET = 32'h0000_1800;

  // environment call from machine mode.
  localparam xlen_t MCAUSE_ECALL_M = 32'd11;

endpackage

`default_nettype wire

// File: logic/commit_queue.sv
`timescale 1ns/1ps
`default_nettype none

module commit_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    push,
  input  rf_pkg::xlen_t          push_pc,
  input  rf_pkg::reg_idx_t       push_rd,
  input  wire                    push_gpr_wen,
  input  rf_pkg::xlen_t          push_gpr_wdata,
  input  wire                    push_ecall,
  input  wire                    push_mret,
  input  wire [3:0]              push_csr_wen,
  input  rf_pkg::xlen_t          push_csr_wdata,
  input  wire                    hold,
  output logic                   full,
  output logic                   pending,
  output logic                   head_valid,
  output rf_pkg::xlen_t          head_pc,
  output rf_pkg::reg_idx_t       head_rd,
  output logic                   head_gpr_wen,
  output rf_pkg::xlen_t          head_gpr_wdata,
  output logic                   head_ecall,
  output logic                   head_mret,
  output logic [3:0]             head_csr_wen,
  output rf_pkg::xlen_t          head_csr_wdata
);

  import rf_pkg::*;

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  // record storage, one array per field.
  xlen_t    pc_mem        [QUEUE_DEPTH];
  reg_idx_t rd_mem        [QUEUE_DEPTH];
  logic     gpr_wen_mem   [QUEUE_DEPTH];
  xlen_t    gpr_wdata_mem [QUEUE_DEPTH];
  logic     ecall_mem     [QUEUE_DEPTH];
  logic     mret_mem      [QUEUE_DEPTH];
  logic [3:0] csr_wen_mem [QUEUE_DEPTH];
  xlen_t    csr_wdata_mem [QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign pending    = (count != '0);
  assign full       = (count == CNT_W'(QUEUE_DEPTH));
  assign head_valid = pending;

  // a strobe while full is dropped.
  assign do_push = push && !full;
  assign do_pop  = head_valid && !hold;

  always_ff @(posedge clk) begin
    if (do_push) begin
      pc_mem[wr_ptr]        <= push_pc;
      rd_mem[wr_ptr]        <= push_rd;
      gpr_wen_mem[wr_ptr]   <= push_gpr_wen;
      gpr_wdata_mem[wr_ptr] <= push_gpr_wdata;
      ecall_mem[wr_ptr]     <= push_ecall;
      mret_mem[wr_ptr]      <= push_mret;
      csr_wen_mem[wr_ptr]   <= push_csr_wen;
      csr_wdata_mem[wr_ptr] <= push_csr_wdata;
    end
  end

  // pointers wrap explicitly so any depth works.
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  assign head_pc        = pc_mem[rd_ptr];
  assign head_rd        = rd_mem[rd_ptr];
  assign head_gpr_wen   = gpr_wen_mem[rd_ptr];
  assign head_gpr_wdata = gpr_wdata_mem[rd_ptr];
  assign head_ecall     = ecall_mem[rd_ptr];
  assign head_mret      = mret_mem[rd_ptr];
  assign head_csr_wen   = csr_wen_mem[rd_ptr];
  assign head_csr_wdata = csr_wdata_mem[rd_ptr];

endmodule

`default_nettype wire

// File: regfile/gpr_file.sv
`timescale 1ns/1ps
`default_nettype none

module gpr_file (
  input  wire              clk,
  input  wire              reset,
  input  wire              wen,
  input  rf_pkg::reg_idx_t waddr,
  input  rf_pkg::xlen_t    wdata,
  input  rf_pkg::reg_idx_t raddr1,
  input  rf_pkg::reg_idx_t raddr2,
  output rf_pkg::xlen_t    rdata1,
  output rf_pkg::xlen_t    rdata2
);

  import rf_pkg::*;

  xlen_t regs [16];

  // x0 is never written, so it keeps its reset value of zero.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // asynchronous read ports for decode.
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

// File: regfile/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file (
  input  wire               clk,
  input  wire               reset,
  input  wire               commit,
  input  rf_pkg::xlen_t     pc,
  input  wire               ecall,
  input  wire               mret,
  // bit 3 mtvec, bit 2 mepc, bit 1 mstatus, bit 0 mcause.
  input  wire [3:0]         csr_wen,
  input  rf_pkg::xlen_t     csr_wdata,
  input  rf_pkg::csr_addr_t raddr,
  input  wire               rd_ecall,
  input  wire               rd_mret,
  output rf_pkg::xlen_t     rdata
);

  import rf_pkg::*;

  xlen_t mtvec;
  xlen_t mepc;
  xlen_t mstatus;
  xlen_t mcause;

  logic  mtvec_wen;
  logic  mepc_wen;
  logic  mstatus_wen;
  logic  mcause_wen;

  xlen_t mepc_next;
  xlen_t mstatus_next;
  xlen_t mcause_next;
  xlen_t mstatus_mret;
  xlen_t addr_data;

  assign mtvec_wen   = commit && csr_wen[3];
  assign mepc_wen    = commit && (ecall || csr_wen[2]);
  assign mstatus_wen = commit && (ecall || mret || csr_wen[1]);
  assign mcause_wen  = commit && (ecall || csr_wen[0]);

  // on mret MIE takes MPIE, MPIE is set and MPP is cleared.
  always_comb begin
    mstatus_mret        = mstatus;
    mstatus_mret[3]     = mstatus[7];
    mstatus_mret[7]     = 1'b1;
    mstatus_mret[12:11] = 2'b00;
  end

  // trap updates override explicit writes.
  assign mepc_next   = ecall ? pc : csr_wdata;
  assign mcause_next = ecall ? MCAUSE_ECALL_M : csr_wdata;
  assign mstatus_next = ecall ? MSTATUS_RESET :
                        mret  ? mstatus_mret :
                        csr_wdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      mtvec   <= '0;
      mepc    <= '0;
      mstatus <= MSTATUS_RESET;
      mcause  <= '0;
    end else begin
      if (mtvec_wen) begin
        mtvec <= csr_wdata;
      end
      if (mepc_wen) begin
        mepc <= mepc_next;
      end
      if (mstatus_wen) begin
        mstatus <= mstatus_next;
      end
      if (mcause_wen) begin
        mcause <= mcause_next;
      end
    end
  end

  // unknown addresses read zero.
  always_comb begin
    case (raddr)
      CSR_MSTATUS:   addr_data = mstatus;
      CSR_MTVEC:     addr_data = mtvec;
      CSR_MEPC:      addr_data = mepc;
      CSR_MCAUSE:    addr_data = mcause;
      CSR_MVENDORID: addr_data = MVENDORID_VALUE;
      CSR_MARCHID:   addr_data = MARCHID_VALUE;
      default:       addr_data = '0;
    endcase
  end

  // decode needs the trap vector for ecall and the return pc for mret.
  assign rdata = rd_ecall ? mtvec :
                 rd_mret  ? mepc  :
                 addr_data;

endmodule

`default_nettype wire

// File: logic/rf_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module rf_subsys #(
  parameter int QUEUE_DEPTH = 4
) (
  input  wire               clk,
  input  wire               reset,
  input  wire               wb_valid,
  input  rf_pkg::xlen_t     wb_pc,
  input  rf_pkg::reg_idx_t  wb_rd,
  input  wire               wb_gpr_wen,
  input  rf_pkg::xlen_t     wb_gpr_wdata,
  input  wire               wb_ecall,
  input  wire               wb_mret,
  input  wire [3:0]         wb_csr_wen,
  input  rf_pkg::xlen_t     wb_csr_wdata,
  input  wire               commit_hold,
  output logic              wb_full,
  output logic              wb_pending,
  input  rf_pkg::reg_idx_t  rs1,
  input  rf_pkg::reg_idx_t  rs2,
  input  rf_pkg::csr_addr_t csr_addr,
  input  wire               rd_ecall,
  input  wire               rd_mret,
  output rf_pkg::xlen_t     src1,
  output rf_pkg::xlen_t     src2,
  output rf_pkg::xlen_t     csr_data
);

  import rf_pkg::*;

  logic       head_valid;
  xlen_t      head_pc;
  reg_idx_t   head_rd;
  logic       head_gpr_wen;
  xlen_t      head_gpr_wdata;
  logic       head_ecall;
  logic       head_mret;
  logic [3:0] head_csr_wen;
  xlen_t      head_csr_wdata;
  logic       commit;

  // the head is applied and popped on the same edge.
  assign commit = head_valid && !commit_hold;

  commit_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) queue_inst (
    .clk            (clk),
    .reset          (reset),
    .push           (wb_valid),
    .push_pc        (wb_pc),
    .push_rd        (wb_rd),
    .push_gpr_wen   (wb_gpr_wen),
    .push_gpr_wdata (wb_gpr_wdata),
    .push_ecall     (wb_ecall),
    .push_mret      (wb_mret),
    .push_csr_wen   (wb_csr_wen),
    .push_csr_wdata (wb_csr_wdata),
    .hold           (commit_hold),
    .full           (wb_full),
    .pending        (wb_pending),
    .head_valid     (head_valid),
    .head_pc        (head_pc),
    .head_rd        (head_rd),
    .head_gpr_wen   (head_gpr_wen),
    .head_gpr_wdata (head_gpr_wdata),
    .head_ecall     (head_ecall),
    .head_mret      (head_mret),
    .head_csr_wen   (head_csr_wen),
    .head_csr_wdata (head_csr_wdata)
  );

  gpr_file gpr_inst (
    .clk    (clk),
    .reset  (reset),
    .wen    (commit && head_gpr_wen),
    .waddr  (head_rd),
    .wdata  (head_gpr_wdata),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .rdata1 (src1),
    .rdata2 (src2)
  );

  csr_file csr_inst (
    .clk       (clk),
    .reset     (reset),
    .commit    (commit),
    .pc        (head_pc),
    .ecall     (head_ecall),
    .mret      (head_mret),
    .csr_wen   (head_csr_wen),
    .csr_wdata (head_csr_wdata),
    .raddr     (csr_addr),
    .rd_ecall  (rd_ecall),
    .rd_mret   (rd_mret),
    .rdata     (csr_data)
  );

endmodule

`default_nettype wire

// File: dv/rf_subsys_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rf_subsys_checker #(
  parameter int QUEUE_DEPTH = 4
) (
  input  wire                                  clk,
  input  wire                                  reset,
  input  wire                                  wb_valid,
  input  wire                                  wb_full,
  input  wire                                  wb_pending,
  input  rf_pkg::reg_idx_t                     rs1,
  input  rf_pkg::xlen_t                        src1,
  input  wire [$clog2(QUEUE_DEPTH + 1)-1:0]    occupancy
);

  // writeback must not strobe into a full queue.
  no_push_when_full_a : assert property (
    @(posedge clk) disable iff (reset) wb_full |-> !wb_valid
  ) else $error("wb_valid strobed while wb_full is high");

  occupancy_bound_a : assert property (
    @(posedge clk) disable iff (reset) int'(occupancy) <= QUEUE_DEPTH
  ) else $error("commit queue occupancy above its depth");

  // x0 is hardwired to zero.
  x0_reads_zero_a : assert property (
    @(posedge clk) disable iff (reset) (rs1 == '0) |-> (src1 == '0)
  ) else $error("src1 nonzero while rs1 selects x0");

  status_after_reset_a : assert property (
    @(posedge clk) reset |=> (!wb_full && !wb_pending)
  ) else $error("wb_full or wb_pending high in the cycle after reset");

endmodule

bind rf_subsys rf_subsys_checker #(
  .QUEUE_DEPTH (QUEUE_DEPTH)
) checker_inst (
  .clk        (clk),
  .reset      (reset),
  .wb_valid   (wb_valid),
  .wb_full    (wb_full),
  .wb_pending (wb_pending),
  .rs1        (rs1),
  .src1       (src1),
  .occupancy  (queue_inst.count)
);

`default_nettype wire

// File: dv/rf_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rf_subsys_tb;

  import rf_pkg::*;

  localparam int CLK_PERIOD        = 8;
  localparam int NUM_TESTS         = 6;
  localparam int TEST_CYCLE_BUDGET = 2000;
  localparam int WAIT_LIMIT        = 200;

  logic       clk = 1'b0;
  logic       reset;
  logic       wb_valid;
  xlen_t      wb_pc;
  reg_idx_t   wb_rd;
  logic       wb_gpr_wen;
  xlen_t      wb_gpr_wdata;
  logic       wb_ecall;
  logic       wb_mret;
  logic [3:0] wb_csr_wen;
  xlen_t      wb_csr_wdata;
  logic       commit_hold;
  logic       wb_full;
  logic       wb_pending;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  csr_addr_t  csr_addr;
  logic       rd_ecall;
  logic       rd_mret;
  xlen_t      src1;
  xlen_t      src2;
  xlen_t      csr_data;

  // expected committed state.
  xlen_t model_gpr [16];
  xlen_t model_mtvec;
  xlen_t model_mepc;
  xlen_t model_mstatus;
  xlen_t model_mcause;

  // the verdict line has been printed.
  bit verdict_printed = 1'b0;

  rf_subsys rf_subsys_inst (
    .clk          (clk),
    .reset        (reset),
    .wb_valid     (wb_valid),
    .wb_pc        (wb_pc),
    .wb_rd        (wb_rd),
    .wb_gpr_wen   (wb_gpr_wen),
    .wb_gpr_wdata (wb_gpr_wdata),
    .wb_ecall     (wb_ecall),
    .wb_mret      (wb_mret),
    .wb_csr_wen   (wb_csr_wen),
    .wb_csr_wdata (wb_csr_wdata),
    .commit_hold  (commit_hold),
    .wb_full      (wb_full),
    .wb_pending   (wb_pending),
    .rs1          (rs1),
    .rs2          (rs2),
    .csr_addr     (csr_addr),
    .rd_ecall     (rd_ecall),
    .rd_mret      (rd_mret),
    .src1         (src1),
    .src2         (src2),
    .csr_data     (csr_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run(input string what);
    $display("%s", what);
    verdict_printed = 1'b1;
    $display("Verification failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input xlen_t expected, input xlen_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH time=%0t signal=%s expected=0x%08h actual=0x%08h",
                          $time, name, expected, actual));
    end
  endtask

  initial begin
    #(NUM_TESTS * TEST_CYCLE_BUDGET * CLK_PERIOD);
    abort_run("timeout: the tests did not finish in their cycle budget");
  end

  final begin
    if (!verdict_printed) begin
      $display("Verification failed");
    end
  end

  task automatic reset_model();
    for (int i = 0; i < 16; i++) model_gpr[i] = '0;
    model_mtvec   = '0;
    model_mepc    = '0;
    model_mstatus = 32'h0000_1800;
    model_mcause  = '0;
  endtask

  // one record as the state should apply it.
  task automatic apply_to_model(input xlen_t pc, input reg_idx_t rd, input logic gpr_wen,
                                input xlen_t gpr_wdata, input logic ecall, input logic mret,
                                input logic [3:0] csr_wen, input xlen_t csr_wdata);
    xlen_t status;
    if (gpr_wen && rd != 4'd0) model_gpr[rd] = gpr_wdata;
    if (csr_wen[3]) model_mtvec = csr_wdata;
    if (ecall) begin
      model_mepc    = pc;
      model_mcause  = 32'd11;
      model_mstatus = 32'h0000_1800;
    end else begin
      if (csr_wen[2]) model_mepc = csr_wdata;
      if (csr_wen[0]) model_mcause = csr_wdata;
      if (mret) begin
        status        = model_mstatus;
        status[3]     = model_mstatus[7];
        status[7]     = 1'b1;
        status[12:11] = 2'b00;
        model_mstatus = status;
      end else if (csr_wen[1]) begin
        model_mstatus = csr_wdata;
      end
    end
  endtask

  task automatic push_record(input xlen_t pc, input reg_idx_t rd, input logic gpr_wen,
                             input xlen_t gpr_wdata, input logic ecall, input logic mret,
                             input logic [3:0] csr_wen, input xlen_t csr_wdata);
    int waited;
    waited = 0;
    @(negedge clk);
    while (wb_full) begin
      waited++;
      if (waited > WAIT_LIMIT) abort_run("commit queue stayed full, record never accepted");
      @(negedge clk);
    end
    @(posedge clk);
    wb_valid     <= 1'b1;
    wb_pc        <= pc;
    wb_rd        <= rd;
    wb_gpr_wen   <= gpr_wen;
    wb_gpr_wdata <= gpr_wdata;
    wb_ecall     <= ecall;
    wb_mret      <= mret;
    wb_csr_wen   <= csr_wen;
    wb_csr_wdata <= csr_wdata;
    @(posedge clk);
    wb_valid <= 1'b0;
    apply_to_model(pc, rd, gpr_wen, gpr_wdata, ecall, mret, csr_wen, csr_wdata);
  endtask

  task automatic gpr_write(input reg_idx_t rd, input xlen_t data);
    push_record($urandom(), rd, 1'b1, data, 1'b0, 1'b0, 4'b0000, '0);
  endtask

  task automatic csr_write(input logic [3:0] mask, input xlen_t data);
    push_record($urandom(), '0, 1'b0, '0, 1'b0, 1'b0, mask, data);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    @(posedge clk);
    commit_hold <= 1'b0;
    @(negedge clk);
    while (wb_pending) begin
      waited++;
      if (waited > WAIT_LIMIT) abort_run("wb_pending did not fall after the hold was released");
      @(negedge clk);
    end
  endtask

  task automatic check_gpr_pair(input reg_idx_t a, input reg_idx_t b);
    @(posedge clk);
    rs1 <= a;
    rs2 <= b;
    @(negedge clk);
    check_value($sformatf("src1[x%0d]", a), model_gpr[a], src1);
    check_value($sformatf("src2[x%0d]", b), model_gpr[b], src2);
  endtask

  task automatic check_csr(input string name, input csr_addr_t addr, input logic sel_ecall,
                           input logic sel_mret, input xlen_t expected);
    @(posedge clk);
    csr_addr <= addr;
    rd_ecall <= sel_ecall;
    rd_mret  <= sel_mret;
    @(negedge clk);
    check_value(name, expected, csr_data);
  endtask

  task automatic compare_all_state();
    for (int i = 0; i < 16; i++) check_gpr_pair(reg_idx_t'(i), reg_idx_t'(15 - i));
    check_csr("csr_data[mstatus]", CSR_MSTATUS, 1'b0, 1'b0, model_mstatus);
    check_csr("csr_data[mtvec]", CSR_MTVEC, 1'b0, 1'b0, model_mtvec);
    check_csr("csr_data[mepc]", CSR_MEPC, 1'b0, 1'b0, model_mepc);
    check_csr("csr_data[mcause]", CSR_MCAUSE, 1'b0, 1'b0, model_mcause);
  endtask

  task automatic test_reset_state();
    compare_all_state();
    check_csr("csr_data[mvendorid]", CSR_MVENDORID, 1'b0, 1'b0, MVENDORID_VALUE);
    check_csr("csr_data[marchid]", CSR_MARCHID, 1'b0, 1'b0, MARCHID_VALUE);
    check_csr("csr_data[0x7c0]", 12'h7C0, 1'b0, 1'b0, 32'h0);
    check_value("wb_full", 32'h0, 32'(wb_full));
    check_value("wb_pending", 32'h0, 32'(wb_pending));
  endtask

  task automatic test_gpr_writes();
    for (int i = 0; i < 16; i++) gpr_write(reg_idx_t'(i), $urandom());
    wait_drain();
    for (int i = 0; i < 16; i++) begin
      for (int j = 0; j < 16; j++) check_gpr_pair(reg_idx_t'(i), reg_idx_t'(j));
    end
    check_gpr_pair(4'd0, 4'd0);
    check_value("src1[x0]", 32'h0, src1);
  endtask

  task automatic test_csr_writes();
    csr_write(4'b1000, $urandom());
    csr_write(4'b0100, $urandom());
    csr_write(4'b0010, $urandom());
    csr_write(4'b0001, $urandom());
    wait_drain();
    compare_all_state();
    // the select lines override whatever address decode presents.
    check_csr("csr_data[rd_ecall]", CSR_MCAUSE, 1'b1, 1'b0, model_mtvec);
    check_csr("csr_data[rd_mret]", CSR_MCAUSE, 1'b0, 1'b1, model_mepc);
  endtask

  task automatic test_trap_flow();
    xlen_t trap_pc;
    xlen_t status_value;
    trap_pc = $urandom();
    push_record(trap_pc, '0, 1'b0, '0, 1'b1, 1'b0, 4'b0000, '0);
    wait_drain();
    check_csr("csr_data[mepc]", CSR_MEPC, 1'b0, 1'b0, trap_pc);
    check_csr("csr_data[mcause]", CSR_MCAUSE, 1'b0, 1'b0, 32'd11);
    check_csr("csr_data[mstatus]", CSR_MSTATUS, 1'b0, 1'b0, 32'h0000_1800);
    // MPIE and MPP set, MIE clear.
    status_value = ($urandom() | 32'h0000_1880) & ~32'h0000_0008;
    csr_write(4'b0010, status_value);
    push_record($urandom(), '0, 1'b0, '0, 1'b0, 1'b1, 4'b0000, '0);
    wait_drain();
    check_csr("csr_data[mstatus]", CSR_MSTATUS, 1'b0, 1'b0, model_mstatus);
    check_value("mstatus.MIE", 32'h1, 32'(csr_data[3]));
    check_csr("csr_data[rd_mret]", CSR_MCAUSE, 1'b0, 1'b1, trap_pc);
  endtask

  task automatic test_back_pressure();
    int       depth;
    reg_idx_t target;
    xlen_t    old_value;
    xlen_t    last_value;
    depth      = rf_subsys_inst.QUEUE_DEPTH;
    target     = reg_idx_t'($urandom_range(1, 15));
    old_value  = model_gpr[target];
    last_value = '0;
    @(posedge clk);
    commit_hold <= 1'b1;
    for (int i = 0; i < depth; i++) begin
      last_value = $urandom();
      gpr_write(target, last_value);
    end
    @(posedge clk);
    rs1 <= target;
    @(negedge clk);
    check_value("wb_full", 32'h1, 32'(wb_full));
    check_value("src1 under hold", old_value, src1);
    wait_drain();
    check_gpr_pair(target, target);
    check_value("src1 after drain", last_value, src1);
  endtask

  task automatic test_random_mix();
    int       kind;
    logic     was_full;
    xlen_t    pc;
    reg_idx_t rd;
    for (int n = 0; n < 200; n++) begin
      @(negedge clk);
      was_full = wb_full;
      // a full queue gets its hold released so it can drain.
      @(posedge clk);
      commit_hold <= was_full ? 1'b0 : ($urandom_range(0, 2) == 0);
      kind = $urandom_range(0, 9);
      pc   = $urandom();
      rd   = reg_idx_t'($urandom_range(0, 15));
      if (kind < 6) begin
        gpr_write(rd, $urandom());
      end else if (kind < 8) begin
        push_record(pc, rd, $urandom_range(0, 1) == 1, $urandom(), 1'b0, 1'b0,
                    4'($urandom_range(1, 15)), $urandom());
      end else begin
        push_record(pc, '0, 1'b0, '0, kind == 8, kind == 9, 4'b0000, '0);
      end
    end
    wait_drain();
    compare_all_state();
  endtask

  initial begin
    void'($urandom(32'h0906_2fd3));
    reset        = 1'b1;
    wb_valid     = 1'b0;
    wb_pc        = '0;
    wb_rd        = '0;
    wb_gpr_wen   = 1'b0;
    wb_gpr_wdata = '0;
    wb_ecall     = 1'b0;
    wb_mret      = 1'b0;
    wb_csr_wen   = 4'b0000;
    wb_csr_wdata = '0;
    commit_hold  = 1'b0;
    rs1          = '0;
    rs2          = '0;
    csr_addr     = '0;
    rd_ecall     = 1'b0;
    rd_mret      = 1'b0;
    reset_model();
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    test_reset_state();
    test_gpr_writes();
    test_csr_writes();
    test_trap_flow();
    test_back_pressure();
    test_random_mix();
    verdict_printed = 1'b1;
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: rf_subsys.f
common/rf_pkg.sv
logic/commit_queue.sv
regfile/gpr_file.sv
regfile/csr_file.sv
logic/rf_subsys.sv
dv/rf_subsys_checker.sv
dv/rf_subsys_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and judges the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -j 0 --top-module rf_subsys_tb -f rf_subsys.f \
  -o rf_subsys_sim > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }

./obj_dir/rf_subsys_sim > "$LOG" 2>&1
cat "$LOG"

grep -q "Verification failed" "$LOG" && { echo "simulation reported an error"; exit 1; }
grep -q "Verification passed" "$LOG" || { echo "simulation ended abnormally"; exit 1; }
exit 0
